/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cpu_core
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
logic/stack_cpu_pkg.sv
logic/ctrl_if.sv
logic/insn_decoder.sv
logic/seq_fsm.sv
logic/ip_counter.sv
logic/lifo_stack.sv
logic/stack_alu.sv
logic/cpu_core.sv
sim/tb_cpu_core.sv

/* logic/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core import stack_cpu_pkg::*; #(
  parameter int STACK_DEPTH  = 16,
  parameter int CSTACK_DEPTH = 8
)
(
  input  logic  clk,
  input  logic  reset,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  word_t mem_rdata,
  output logic  mem_rd,
  output logic  mem_wr,
  output logic  mem_byte
);

  ctrl_if ctl ();

  cpu_state_e state;
  logic  fetch_en, latch_insn, exec_en, mem_en;
  logic  ld_pend, br_skip, dstk_empty;
  word_t insn_q, stk0, stk1, fp, ip, addr_q;
  word_t op_a, op_b, imm_val, alu_result;
  word_t dstk_top, cstk_top, cstk_din;

  insn_decoder u_dec (.insn(insn_q), .ctl(ctl.dec));

  seq_fsm u_seq (
    .clk, .reset, .ctl(ctl.seq),
    .fetch_en, .latch_insn, .exec_en, .mem_en, .state
  );

  // the masks keep a run of low bits, so sign fills all bits above it
  assign imm_val = (insn_q & ctl.imm_mask)
                 | (ctl.sign ? ~(ctl.imm_mask | 16'h0001) : 16'h0000);

  always_comb
  begin
    case (ctl.src_a)
      SRC_STK0: op_a = stk0;
      SRC_FP:   op_a = fp;
      SRC_IP:   op_a = ip;
      default:  op_a = cstk_top;
    endcase
  end

  assign op_b = ctl.imm ? imm_val : stk1;

  stack_alu u_alu (.op(ctl.alu_sel), .a(op_a), .b(op_b), .stk0, .result(alu_result));

  // high when a branch is not taken and ip just steps
  assign br_skip = (ctl.alu_sel == ALU_ADDZ && stk0 != '0)
                || (ctl.alu_sel == ALU_ADDNZ && stk0 == '0);

  ip_counter u_ip (
    .clk, .reset, .inc(exec_en),
    .load(exec_en & ctl.load_ip & ~br_skip), .target(alu_result), .ip
  );

  assign cstk_din = (ctl.src_a == SRC_IP) ? ip + 16'd1 : alu_result;   // call saves ip+1

  lifo_stack #(.DEPTH(STACK_DEPTH)) u_dstk (
    .clk, .reset,
    .push (exec_en & ctl.push & ~ctl.pop),
    .pop  (exec_en & ctl.pop & ~ctl.push & ~dstk_empty),
    .din  (stk1),
    .top  (dstk_top),
    .empty(dstk_empty),
    .full ()
  );

  lifo_stack #(.DEPTH(CSTACK_DEPTH)) u_cstk (
    .clk, .reset,
    .push (exec_en & ctl.cpush),
    .pop  (exec_en & ctl.cpop),
    .din  (cstk_din),
    .top  (cstk_top),
    .empty(),
    .full ()
  );

  always_ff @(posedge clk)
  begin
    if (latch_insn)
      insn_q <= mem_rdata;
    if (exec_en)
    begin
      addr_q    <= alu_result;   // held for the mem cycle
      mem_wdata <= stk1;
    end
    if (ld_pend)
      stk0 <= ctl.byt ? {8'h00, mem_rdata[7:0]} : mem_rdata;
    else if (exec_en && ctl.load_stk)
      stk0 <= alu_result;
    else if (exec_en && ctl.pop)
      stk0 <= stk1;
    if (exec_en)
    begin
      if (ctl.wr_stk1 || (ctl.push && !ctl.pop))
        stk1 <= stk0;
      else if (ctl.pop && !ctl.push)
        stk1 <= dstk_empty ? '0 : dstk_top;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      fp      <= '0;
      ld_pend <= 1'b0;
    end
    else
    begin
      ld_pend <= mem_en & ctl.rd_mem;
      if (exec_en && ctl.load_fp)
        fp <= alu_result;
    end
  end

  assign mem_addr = (state == S_MEM) ? addr_q : ip;
  assign mem_rd   = fetch_en | (mem_en & ctl.rd_mem);
  assign mem_wr   = mem_en & ctl.wr_mem;
  assign mem_byte = mem_en & ctl.byt;

endmodule

`default_nettype wire

/* logic/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if import stack_cpu_pkg::*; ();

  logic    imm;        // operand b comes from the instruction, not stk1
  logic    sign;
  word_t   imm_mask;
  src_a_e  src_a;
  alu_op_e alu_sel;
  logic    wr_stk1, pop, push, load_stk, load_fp, load_ip;
  logic    cpop, cpush, byt, rd_mem, wr_mem;

  modport dec (
    output imm, sign, imm_mask, src_a, alu_sel, wr_stk1, pop, push, load_stk,
           load_fp, load_ip, cpop, cpush, byt, rd_mem, wr_mem
  );

  modport seq (input rd_mem, wr_mem);

  modport dp (
    input imm, sign, imm_mask, src_a, alu_sel, wr_stk1, pop, push, load_stk,
          load_fp, load_ip, cpop, cpush, byt, rd_mem, wr_mem
  );

endinterface

`default_nettype wire

/* logic/insn_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_decoder import stack_cpu_pkg::*;
(
  input word_t insn,
  ctrl_if.dec  ctl
);

  logic cls7;

  assign cls7        = insn[15:12] == 4'h7;
  assign ctl.imm     = !cls7;
  assign ctl.wr_stk1 = cls7 & insn[3];
  assign ctl.byt     = insn[14] & insn[0];

  always_comb
  begin
    casez (insn[15:12])
      4'b000?:          ctl.sign = insn[11];   // jump offset
      4'b001?, 4'b0100: ctl.sign = insn[9];
      default:          ctl.sign = 1'b0;
    endcase

    casez (insn[15:12])
      4'b1???: ctl.imm_mask = 16'h7fff;
      4'b000?: ctl.imm_mask = 16'h0ffe;
      4'b001?: ctl.imm_mask = 16'h03fe;
      default: ctl.imm_mask = 16'h03ff;
    endcase

    casez (insn)
      16'b000?_????_????_????: ctl.src_a = SRC_IP;
      16'b001?_????_????_????: ctl.src_a = src_a_e'(insn[11:10]);
      16'b0100_????_????_????: ctl.src_a = SRC_FP;
      16'b0111_1???_????_00?0: ctl.src_a = SRC_CSTK;
      16'b0111_1???_????_0011: ctl.src_a = SRC_FP;
      default:                 ctl.src_a = SRC_STK0;
    endcase

    casez (insn)
      16'b1???_????_????_????: ctl.alu_sel = ALU_B;
      16'b0001_????_????_???0: ctl.alu_sel = ALU_ADDZ;
      16'b0001_????_????_???1: ctl.alu_sel = ALU_ADDNZ;
      16'b001?_00??_????_????: ctl.alu_sel = ALU_B;     // absolute address
      16'b0111_0???_????_????: ctl.alu_sel = alu_op_e'(insn[5:0]);
      16'b0111_1???_????_????: ctl.alu_sel = ALU_A;
      default:                 ctl.alu_sel = ALU_ADD;
    endcase
  end

  assign ctl.push = insn ==? 16'b1???_????_????_???? || insn ==? 16'b0010_????_????_???0
                 || insn ==? 16'b0011_????_????_???? || insn ==? 16'b0111_????_1???_????;

  assign ctl.pop = insn ==? 16'b0001_????_????_???? || insn ==? 16'b0010_????_????_???1
                || insn ==? 16'b0111_0???_?1??_???? || insn ==? 16'b0111_1???_????_?1??;

  assign ctl.load_stk = ctl.push || insn ==? 16'b0111_0???_????_????
                     || insn ==? 16'b0111_1???_????_1?0?;

  assign ctl.load_fp = insn ==? 16'b0100_????_????_????
                    || insn ==? 16'b0111_1???_????_0010;

  // relative jump, call, branch and return
  assign ctl.load_ip = insn ==? 16'b000?_????_????_????
                    || insn ==? 16'b0111_1???_????_0000;

  assign ctl.cpop  = insn ==? 16'b0111_1???_????_00?0;
  assign ctl.cpush = insn ==? 16'b0000_????_????_???1 || insn ==? 16'b0111_1???_????_0011;

  assign ctl.rd_mem = insn ==? 16'b0010_????_????_???0 || insn ==? 16'b0111_1???_????_10??;
  assign ctl.wr_mem = insn ==? 16'b0010_????_????_???1 || insn ==? 16'b0111_1???_????_11??;

  always_comb
  begin
    if (!$isunknown(insn))
    begin
      assert (ctl.alu_sel inside {[ALU_A:ALU_SHL], [ALU_SHR:ALU_ADDNZ]})
        else $error("undefined alu op %0h", ctl.alu_sel);
      assert (!(ctl.push && ctl.cpop))
        else $error("push together with call-stack pop, insn %04h", insn);
    end
  end

endmodule

`default_nettype wire

/* logic/ip_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_counter import stack_cpu_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  inc,
  input  logic  load,
  input  word_t target,
  output word_t ip
);

  always_ff @(posedge clk)
  begin
    if (reset)
      ip <= '0;
    else if (load)
      ip <= target;   // a jump replaces the increment
    else if (inc)
      ip <= ip + 16'd1;
  end

endmodule

`default_nettype wire

/* logic/lifo_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module lifo_stack import stack_cpu_pkg::*; #(
  parameter int DEPTH = 16
)
(
  input  logic  clk,
  input  logic  reset,
  input  logic  push,
  input  logic  pop,
  input  word_t din,
  output word_t top,
  output logic  empty,
  output logic  full
);

  localparam int AW = $clog2(DEPTH);

  word_t         mem [DEPTH];
  logic [AW:0]   count;   // entries held
  logic [AW-1:0] top_idx;

  assign top_idx = count[AW-1:0] - 1'b1;
  assign top     = mem[top_idx];
  assign empty   = count == '0;
  assign full    = count == (AW+1)'(DEPTH);

  always_ff @(posedge clk)
  begin
    if (reset)
      count <= '0;
    else if (push && !pop)
      count <= count + 1'b1;
    else if (pop && !push)
      count <= count - 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (push && pop)
      mem[top_idx] <= din;   // replace top
    else if (push)
      mem[count[AW-1:0]] <= din;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    full |-> !(push && !pop));
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    empty |-> !pop);

endmodule

`default_nettype wire

/* logic/seq_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_fsm import stack_cpu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  ctrl_if.seq        ctl,
  output logic       fetch_en,
  output logic       latch_insn,
  output logic       exec_en,
  output logic       mem_en,
  output cpu_state_e state
);

  cpu_state_e next;
  logic       run;   // low until the first clock after reset

  always_comb
  begin
    case (state)
      S_FETCH:  next = S_DECODE;
      S_DECODE: next = S_EXEC;
      S_EXEC:   next = (ctl.rd_mem || ctl.wr_mem) ? S_MEM : S_FETCH;
      default:  next = S_FETCH;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= S_FETCH;
      run   <= 1'b0;
    end
    else
    begin
      run <= 1'b1;
      if (run)
        state <= next;
    end
  end

  assign fetch_en   = run && state == S_FETCH;
  assign latch_insn = state == S_DECODE;
  assign exec_en    = state == S_EXEC;
  assign mem_en     = state == S_MEM;

  a_mem_after_exec: assert property (@(posedge clk) disable iff (reset)
    state == S_MEM |-> $past(state) == S_EXEC);

endmodule

`default_nettype wire

/* logic/stack_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module stack_alu import stack_cpu_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  input  word_t   stk0,
  output word_t   result
);

  logic zero;

  assign zero = stk0 == '0;

  always_comb
  begin
    case (op)
      ALU_A:     result = a;
      ALU_B:     result = b;
      ALU_ADD:   result = a + b;
      ALU_SUB:   result = a - b;
      ALU_AND:   result = a & b;
      ALU_OR:    result = a | b;
      ALU_XOR:   result = a ^ b;
      ALU_SHL:   result = a << b[3:0];
      ALU_SHR:   result = a >> b[3:0];
      ALU_EQ:    result = {15'd0, a == b};
      ALU_LTU:   result = {15'd0, a < b};
      ALU_ADDZ:  result = zero ? a + b : b;
      ALU_ADDNZ: result = zero ? b : a + b;
      default:   result = a;
    endcase
  end

endmodule

`default_nettype wire

/* logic/stack_cpu_pkg.sv */
`default_nettype none

package stack_cpu_pkg;

  typedef logic [15:0] word_t;

  typedef enum logic [1:0] {
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM
  } cpu_state_e;

  // bit 3 stays clear in every op since the alu class uses it for wr_stk1
  typedef enum logic [5:0] {
    ALU_A     = 6'h00,
    ALU_B     = 6'h01,
    ALU_ADD   = 6'h02,
    ALU_SUB   = 6'h03,
    ALU_AND   = 6'h04,
    ALU_OR    = 6'h05,
    ALU_XOR   = 6'h06,
    ALU_SHL   = 6'h07,
    ALU_SHR   = 6'h10,
    ALU_EQ    = 6'h11,
    ALU_LTU   = 6'h12,
    ALU_ADDZ  = 6'h13,   // a + b if stk0 is zero, else b
    ALU_ADDNZ = 6'h14
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_STK0,
    SRC_FP,
    SRC_IP,
    SRC_CSTK
  } src_a_e;

endpackage

`default_nettype wire

/* sim/tb_cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core import stack_cpu_pkg::*; ();

  localparam int MAX_CYCLES = 5 * 40 * 4 * 2;   // tests x insns x cycles x 2 for margin

  localparam word_t ST_TOP  = 16'h780c;   // mem[stk0] <= stk1
  localparam word_t LD_TOP  = 16'h7808;   // stk0 <= mem[stk0]
  localparam word_t LDB_TOP = 16'h7809;
  localparam word_t RET     = 16'h7800;
  localparam word_t HALT    = 16'h0000;   // jump to self

  logic   clk, reset, mem_rd, mem_wr, mem_byte;
  word_t  mem_addr, mem_wdata, mem_rdata, rd_next;
  word_t  mem [256];
  word_t  rd_addr_q[$], wr_addr_q[$], wr_data_q[$];
  logic   rd_byte_q[$];
  integer seed = 32'h070584d9;
  int     cycles, pc_w, test_errs, total_errs, tests_run;
  string  cur_test;

  cpu_core #(.STACK_DEPTH(16), .CSTACK_DEPTH(8)) dut (
    .clk, .reset, .mem_addr, .mem_wdata, .mem_rdata, .mem_rd, .mem_wr, .mem_byte
  );

  always #20 clk = ~clk;

  // memory model samples the strobes mid cycle
  always @(negedge clk)
  begin
    if (mem_rd)
    begin
      rd_next = mem[mem_addr[7:0]];
      rd_addr_q.push_back(mem_addr);
      rd_byte_q.push_back(mem_byte);
    end
    if (mem_wr)
    begin
      mem[mem_addr[7:0]] = mem_wdata;
      wr_addr_q.push_back(mem_addr);
      wr_data_q.push_back(mem_wdata);
    end
  end

  always @(posedge clk)
  begin
    #2;
    mem_rdata = rd_next;   // answer lands one cycle after the read
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: processor did not reach end of program");
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic word_t push_word(input word_t v);
    return {1'b1, v[14:0]};
  endfunction

  // relative offsets are even and bit 0 selects jump or call
  function automatic word_t jump_rel(input logic [11:0] off);
    return {4'h0, off[11:1], 1'b0};
  endfunction

  function automatic word_t call_rel(input logic [11:0] off);
    return {4'h0, off[11:1], 1'b1};
  endfunction

  function automatic word_t branch_if_zero(input logic [11:0] off);
    return {4'h1, off[11:1], 1'b0};
  endfunction

  function automatic word_t alu_pop(input alu_op_e op);
    return {10'b0111_0000_01, op};   // bit 6 drops stk1
  endfunction

  task automatic place(input word_t w);
    mem[pc_w] = w;
    pc_w++;
  endtask

  task automatic start_test(input string name);
    @(posedge clk);
    #2 reset = 1'b1;
    @(posedge clk);
    #2;
    cur_test  = name;
    test_errs = 0;
    pc_w      = 0;
    foreach (mem[i])
      mem[i] = '0;
    rd_addr_q.delete();
    rd_byte_q.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
  endtask

  task automatic release_reset();
    repeat (9) @(posedge clk);
    #2 reset = 1'b0;
  endtask

  task automatic wait_fetch(input word_t addr);
    @(negedge clk);
    while (!(mem_rd && mem_addr == addr))
      @(negedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp)
    begin
      $display("[ERROR] %s, %s: expected %04h, actual %04h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_flag(input string what, input bit exp, input logic act);
    if (act !== exp)
    begin
      $display("[ERROR] %s, %s: expected %0b, actual %0b", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_read(input int k, input word_t addr);
    if (k >= rd_addr_q.size())
    begin
      $display("%s: memory read number %0d never happened", cur_test, k);
      test_errs++;
    end
    else
      check_word($sformatf("read %0d address", k), addr, rd_addr_q[k]);
  endtask

  task automatic check_write(input word_t addr, input word_t data);
    if (wr_addr_q.size() == 0)
    begin
      $display("%s: the memory write to %04h never happened", cur_test, addr);
      test_errs++;
    end
    else
    begin
      check_word("write address", addr, wr_addr_q.pop_front());
      check_word("write data", data, wr_data_q.pop_front());
    end
  endtask

  task automatic check_no_write();
    if (wr_addr_q.size() != 0)
    begin
      $display("%s: %0d more memory writes than expected", cur_test, wr_addr_q.size());
      test_errs++;
    end
  endtask

  task automatic report_test();
    if (test_errs == 0)
      $display("%s: passed", cur_test);
    else
      $display("%s: failed with %0d mismatches", cur_test, test_errs);
    total_errs += test_errs;
    tests_run++;
  endtask

  task automatic reset_and_fetch();
    start_test("reset_and_fetch");
    place(push_word(16'h0001));
    place(push_word(16'h0002));
    place(HALT);
    release_reset();
    @(negedge clk);
    check_flag("mem_rd after reset", 1'b0, mem_rd);
    check_flag("mem_wr after reset", 1'b0, mem_wr);
    wait_fetch(16'd2);
    check_read(0, 16'd0);
    check_read(1, 16'd1);
    check_read(2, 16'd2);
    check_no_write();
    report_test();
  endtask

  task automatic push_store();
    word_t value;
    value = 16'($random(seed)) & 16'h7fff;
    start_test("push_store");
    place(push_word(value));
    place(push_word(16'h0044));
    place(ST_TOP);
    place(HALT);
    release_reset();
    wait_fetch(16'd3);
    check_write(16'h0044, value);
    check_no_write();
    report_test();
  endtask

  task automatic alu_ops();
    alu_op_e ops [4];
    word_t   x, y;
    word_t   results [4];
    int      k;
    ops = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_LTU};
    x = 16'($random(seed)) & 16'h7fff;
    y = 16'($random(seed)) & 16'h7fff;
    // y is pushed last, so it is operand a
    results[0] = y + x;
    results[1] = y - x;
    results[2] = y ^ x;
    results[3] = (y < x) ? 16'd1 : 16'd0;
    start_test("alu_ops");
    for (k = 0; k < 4; k++)
    begin
      place(push_word(x));
      place(push_word(y));
      place(alu_pop(ops[k]));
      place(push_word(16'h0050 + 16'(k)));
      place(ST_TOP);
    end
    place(HALT);
    release_reset();
    wait_fetch(16'd20);
    for (k = 0; k < 4; k++)
      check_write(16'h0050 + 16'(k), results[k]);
    check_no_write();
    report_test();
  endtask

  task automatic control_flow();
    word_t value;
    word_t path [11];
    int    k;
    value = 16'($random(seed)) & 16'h7fff;
    path  = '{16'd0, 16'd2, 16'd20, 16'd3, 16'd4, 16'd8, 16'd9, 16'd10, 16'd11,
              16'd12, 16'd13};
    start_test("control_flow");
    place(jump_rel(12'd2));         // skips the store at 1
    place(ST_TOP);
    place(call_rel(12'd18));        // subroutine at 20
    place(push_word(16'h0000));
    place(branch_if_zero(12'd4));   // taken to 8
    place(ST_TOP);
    place(ST_TOP);
    place(ST_TOP);
    place(push_word(16'h0005));     // 8
    place(branch_if_zero(12'd4));   // falls through to 10
    place(push_word(value));
    place(push_word(16'h0060));
    place(ST_TOP);
    place(HALT);                    // 13
    pc_w = 20;
    place(RET);
    release_reset();
    wait_fetch(16'd13);
    for (k = 0; k < 11; k++)
      check_read(k, path[k]);
    check_write(16'h0060, value);
    check_no_write();
    report_test();
  endtask

  task automatic load_store();
    word_t word_v, byte_v;
    logic  byte_seen, word_byte;
    int    k;
    word_v = 16'($random(seed));
    byte_v = 16'($random(seed));
    start_test("load_store");
    mem[8'hc0] = word_v;
    mem[8'hc2] = byte_v;
    place(push_word(16'h00c0));
    place(LD_TOP);
    place(push_word(16'h0070));
    place(ST_TOP);
    place(push_word(16'h00c2));
    place(LDB_TOP);
    place(push_word(16'h0071));
    place(ST_TOP);
    place(HALT);                    // 8
    release_reset();
    wait_fetch(16'd8);
    byte_seen = 1'b0;
    word_byte = 1'b0;
    for (k = 0; k < rd_addr_q.size(); k++)
    begin
      if (rd_addr_q[k] == 16'h00c2 && rd_byte_q[k])
        byte_seen = 1'b1;
      if (rd_addr_q[k] == 16'h00c0 && rd_byte_q[k])
        word_byte = 1'b1;
    end
    check_flag("mem_byte on byte load", 1'b1, byte_seen);
    check_flag("mem_byte on word load", 1'b0, word_byte);
    check_write(16'h0070, word_v);
    check_write(16'h0071, byte_v & 16'h00ff);
    check_no_write();
    report_test();
  endtask

  initial
  begin
    clk        = 1'b0;
    reset      = 1'b1;
    mem_rdata  = '0;
    rd_next    = '0;
    cycles     = 0;
    total_errs = 0;
    tests_run  = 0;
    reset_and_fetch();
    push_store();
    alu_ops();
    control_flow();
    load_store();
    $display("tests run: %0d, mismatches: %0d", tests_run, total_errs);
    if (total_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
